// ==== rtl/tile_pkg.sv ====
/* Compute tile bus definitions */

package tile_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  localparam int TILE_AW = 32;
  localparam int TILE_DW = 32;
  localparam int TILE_SW = TILE_DW / 8;

  //////////////////////////////////////////////////////////////////////
  // Memory map
  //////////////////////////////////////////////////////////////////////

  // Local data memory at the bottom of the address space
  localparam int SRAM_WORDS      = 256;
  localparam int SRAM_RANGE_BITS = $clog2(SRAM_WORDS) + 2;

  // Everything above the memory's byte range must be zero
  localparam logic [TILE_AW-SRAM_RANGE_BITS-1:0] SRAM_MATCH = '0;

  // Boot ROM occupies the top 256 MB region
  localparam int               BOOT_MATCH_BITS = 4;
  localparam logic [BOOT_MATCH_BITS-1:0] BOOT_MATCH = 4'hf;
  localparam int               BOOT_WORDS      = 8;

  // Short start-up sequence: set up a stack pointer, then spin
  localparam logic [TILE_DW-1:0] BOOT_IMAGE [BOOT_WORDS] = '{
    32'h1820_0000,
    32'ha821_03fc,
    32'h1860_f000,
    32'ha863_0020,
    32'h8483_0000,
    32'h1500_0001,
    32'h0000_0000,
    32'h1500_0000
  };

  //////////////////////////////////////////////////////////////////////
  // Decoder targets
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SEL_SRAM,
    SEL_BOOT,
    SEL_NONE
  } slave_sel_t;

endpackage

// ==== rtl/wb_if.sv ====
/* Wishbone classic bus */

interface wb_if import tile_pkg::*; #(
  parameter int AW = TILE_AW,
  parameter int DW = TILE_DW
);

  logic [AW-1:0]   adr;
  logic [DW-1:0]   dat_w;
  logic [DW-1:0]   dat_r;
  logic [DW/8-1:0] sel;
  logic            we;
  logic            cyc;
  logic            stb;
  logic            ack;
  logic            err;

  // Request side
  modport master (
    output adr, dat_w, sel, we, cyc, stb,
    input  dat_r, ack, err
  );

  // Response side
  modport slave (
    input  adr, dat_w, sel, we, cyc, stb,
    output dat_r, ack, err
  );

endinterface

// ==== rtl/tile_bus_arbiter.sv ====
/* Two-master round-robin arbiter */

module tile_bus_arbiter #(
  parameter int AW = 32,
  parameter int DW = 32
) (
  input logic   clk,
  input logic   reset_i,
  wb_if.slave   m0,
  wb_if.slave   m1,
  wb_if.master  shared
);

  logic [1:0] req;
  logic       gnt_valid_q;
  logic       gnt_valid_d;
  logic       gnt_idx_q;
  logic       gnt_idx_d;
  logic       last_q;
  logic       last_d;
  logic       gnt_cyc;

  assign req     = {m1.cyc & m1.stb, m0.cyc & m0.stb};
  assign gnt_cyc = gnt_idx_q ? m1.cyc : m0.cyc;

  //////////////////////////////////////////////////////////////////////
  // Grant control
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    gnt_valid_d = gnt_valid_q;
    gnt_idx_d   = gnt_idx_q;
    last_d      = last_q;
    if (gnt_valid_q && !gnt_cyc) begin
      // Owner let go of cyc
      gnt_valid_d = 1'b0;
      last_d      = gnt_idx_q;
      // Hand over directly when the other master waits
      if (req[~gnt_idx_q]) begin
        gnt_valid_d = 1'b1;
        gnt_idx_d   = ~gnt_idx_q;
      end
    end else if (!gnt_valid_q && (|req)) begin
      gnt_valid_d = 1'b1;
      // Tie goes to whoever was not served last
      gnt_idx_d   = (&req) ? ~last_q : req[1];
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      gnt_valid_q <= 1'b0;
      gnt_idx_q   <= 1'b0;
      last_q      <= 1'b1;
    end else begin
      gnt_valid_q <= gnt_valid_d;
      gnt_idx_q   <= gnt_idx_d;
      last_q      <= last_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Request forwarding
  //////////////////////////////////////////////////////////////////////

  assign shared.adr   = !gnt_valid_q ? {AW{1'b0}} : (gnt_idx_q ? m1.adr : m0.adr);
  assign shared.dat_w = !gnt_valid_q ? {DW{1'b0}} : (gnt_idx_q ? m1.dat_w : m0.dat_w);
  assign shared.sel   = gnt_idx_q ? m1.sel : m0.sel;
  assign shared.we    = gnt_valid_q & (gnt_idx_q ? m1.we : m0.we);
  assign shared.cyc   = gnt_valid_q & gnt_cyc;
  assign shared.stb   = gnt_valid_q & (gnt_idx_q ? m1.stb : m0.stb);

  // Response goes only to the owner, the other sees zeros
  assign m0.dat_r = (gnt_valid_q && !gnt_idx_q) ? shared.dat_r : {DW{1'b0}};
  assign m0.ack   = gnt_valid_q & !gnt_idx_q & shared.ack;
  assign m0.err   = gnt_valid_q & !gnt_idx_q & shared.err;

  assign m1.dat_r = (gnt_valid_q && gnt_idx_q) ? shared.dat_r : {DW{1'b0}};
  assign m1.ack   = gnt_valid_q & gnt_idx_q & shared.ack;
  assign m1.err   = gnt_valid_q & gnt_idx_q & shared.err;

endmodule

// ==== rtl/tile_addr_decoder.sv ====
/* Tile address decoder and error slave */

module tile_addr_decoder import tile_pkg::*; #(
  parameter int AW = 32,
  parameter int DW = 32
) (
  input logic   clk,
  input logic   reset_i,
  wb_if.slave   shared,
  wb_if.master  sram,
  wb_if.master  boot
);

  slave_sel_t    sel_q;
  logic          busy_q;
  logic          err_q;
  logic [DW-1:0] rdata;
  logic          slave_ack;
  logic          slave_err;

  // Boot ROM writes fall into the error target as well
  function automatic slave_sel_t classify(input logic [AW-1:0] adr, input logic we);
    if (adr[AW-1:SRAM_RANGE_BITS] == SRAM_MATCH) begin
      return SEL_SRAM;
    end
    if (adr[AW-1:AW-BOOT_MATCH_BITS] == BOOT_MATCH && !we) begin
      return SEL_BOOT;
    end
    return SEL_NONE;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Decode register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      sel_q  <= SEL_NONE;
      err_q  <= 1'b0;
    end else begin
      if (busy_q && (shared.ack || shared.err)) begin
        busy_q <= 1'b0;
      end else if (!busy_q && shared.cyc && shared.stb) begin
        busy_q <= 1'b1;
        sel_q  <= classify(shared.adr, shared.we);
      end
      // Single-cycle error pulse
      err_q <= busy_q & (sel_q == SEL_NONE) & !err_q;
    end
  end

  // Request broadcast, strobe only to the chosen slave
  assign sram.adr   = shared.adr;
  assign sram.dat_w = shared.dat_w;
  assign sram.sel   = shared.sel;
  assign sram.we    = shared.we;
  assign sram.cyc   = shared.cyc & busy_q & (sel_q == SEL_SRAM);
  assign sram.stb   = shared.stb & busy_q & (sel_q == SEL_SRAM);

  assign boot.adr   = shared.adr;
  assign boot.dat_w = shared.dat_w;
  assign boot.sel   = shared.sel;
  assign boot.we    = shared.we;
  assign boot.cyc   = shared.cyc & busy_q & (sel_q == SEL_BOOT);
  assign boot.stb   = shared.stb & busy_q & (sel_q == SEL_BOOT);

  //////////////////////////////////////////////////////////////////////
  // Response mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata     = {DW{1'b0}};
    slave_ack = 1'b0;
    slave_err = 1'b0;
    case (sel_q)
      SEL_SRAM: begin
        rdata     = sram.dat_r;
        slave_ack = sram.ack;
        slave_err = sram.err;
      end
      SEL_BOOT: begin
        rdata     = boot.dat_r;
        slave_ack = boot.ack;
        slave_err = boot.err;
      end
      default: ;
    endcase
  end

  assign shared.dat_r = rdata;
  assign shared.ack   = busy_q & slave_ack;
  assign shared.err   = err_q | (busy_q & slave_err);

endmodule

// ==== rtl/tile_sram.sv ====
/* Local data memory */

module tile_sram #(
  parameter int AW        = 32,
  parameter int DW        = 32,
  parameter int MEM_WORDS = 256
) (
  input logic  clk,
  input logic  reset_i,
  wb_if.slave  bus
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [DW-1:0]   mem [MEM_WORDS];
  logic [DW-1:0]   dat_q;
  logic            ack_q;
  logic [AW-3:0]   word_adr;
  logic [IDX_W-1:0] idx;
  logic            access;

  // Word address wraps at the memory depth
  assign word_adr = bus.adr[AW-1:2];
  assign idx      = word_adr[IDX_W-1:0];
  assign access   = bus.cyc & bus.stb & !ack_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Byte lanes
  always_ff @(posedge clk) begin
    if (access) begin
      if (bus.we) begin
        for (int b = 0; b < DW/8; b++) begin
          if (bus.sel[b]) begin
            mem[idx][b*8 +: 8] <= bus.dat_w[b*8 +: 8];
          end
        end
      end
      dat_q <= mem[idx];
    end
  end

  assign bus.dat_r = dat_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;

endmodule

// ==== rtl/tile_bootrom.sv ====
/* Boot ROM */

module tile_bootrom import tile_pkg::*; #(
  parameter int DW = 32
) (
  input logic  clk,
  input logic  reset_i,
  wb_if.slave  bus
);

  localparam int IDX_W = $clog2(BOOT_WORDS);

  // Word offset inside the ROM region
  logic [TILE_AW-BOOT_MATCH_BITS-3:0] word_idx;
  logic [DW-1:0]                      dat_q;
  logic                               ack_q;
  logic                               access;

  assign word_idx = bus.adr[TILE_AW-BOOT_MATCH_BITS-1:2];
  assign access   = bus.cyc & bus.stb & !ack_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Past the image the region reads as zero
  always_ff @(posedge clk) begin
    if (access) begin
      if (word_idx < BOOT_WORDS) begin
        dat_q <= BOOT_IMAGE[word_idx[IDX_W-1:0]];
      end else begin
        dat_q <= {DW{1'b0}};
      end
    end
  end

  assign bus.dat_r = dat_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;

endmodule

// ==== rtl/tile_top.sv ====
/* Compute tile shared bus */

module tile_top import tile_pkg::*; #(
  parameter int AW        = TILE_AW,
  parameter int DW        = TILE_DW,
  parameter int MEM_WORDS = SRAM_WORDS
) (
  input  logic            clk,
  input  logic            reset_i,

  // Master 0, core data port
  input  logic [AW-1:0]   m0_adr_i,
  input  logic [DW-1:0]   m0_dat_i,
  input  logic [DW/8-1:0] m0_sel_i,
  input  logic            m0_we_i,
  input  logic            m0_cyc_i,
  input  logic            m0_stb_i,
  output logic [DW-1:0]   m0_dat_o,
  output logic            m0_ack_o,
  output logic            m0_err_o,

  // Master 1, network adapter
  input  logic [AW-1:0]   m1_adr_i,
  input  logic [DW-1:0]   m1_dat_i,
  input  logic [DW/8-1:0] m1_sel_i,
  input  logic            m1_we_i,
  input  logic            m1_cyc_i,
  input  logic            m1_stb_i,
  output logic [DW-1:0]   m1_dat_o,
  output logic            m1_ack_o,
  output logic            m1_err_o
);

  wb_if #(.AW(AW), .DW(DW)) m0_bus ();
  wb_if #(.AW(AW), .DW(DW)) m1_bus ();
  wb_if #(.AW(AW), .DW(DW)) shared_bus ();
  wb_if #(.AW(AW), .DW(DW)) sram_bus ();
  wb_if #(.AW(AW), .DW(DW)) boot_bus ();

  //////////////////////////////////////////////////////////////////////
  // Master ports
  //////////////////////////////////////////////////////////////////////

  assign m0_bus.adr   = m0_adr_i;
  assign m0_bus.dat_w = m0_dat_i;
  assign m0_bus.sel   = m0_sel_i;
  assign m0_bus.we    = m0_we_i;
  assign m0_bus.cyc   = m0_cyc_i;
  assign m0_bus.stb   = m0_stb_i;
  assign m0_dat_o     = m0_bus.dat_r;
  assign m0_ack_o     = m0_bus.ack;
  assign m0_err_o     = m0_bus.err;

  assign m1_bus.adr   = m1_adr_i;
  assign m1_bus.dat_w = m1_dat_i;
  assign m1_bus.sel   = m1_sel_i;
  assign m1_bus.we    = m1_we_i;
  assign m1_bus.cyc   = m1_cyc_i;
  assign m1_bus.stb   = m1_stb_i;
  assign m1_dat_o     = m1_bus.dat_r;
  assign m1_ack_o     = m1_bus.ack;
  assign m1_err_o     = m1_bus.err;

  tile_bus_arbiter #(.AW(AW), .DW(DW)) u_arbiter (
    .clk    (clk),
    .reset_i(reset_i),
    .m0     (m0_bus),
    .m1     (m1_bus),
    .shared (shared_bus)
  );

  tile_addr_decoder #(.AW(AW), .DW(DW)) u_decoder (
    .clk    (clk),
    .reset_i(reset_i),
    .shared (shared_bus),
    .sram   (sram_bus),
    .boot   (boot_bus)
  );

  tile_sram #(.AW(AW), .DW(DW), .MEM_WORDS(MEM_WORDS)) u_sram (
    .clk    (clk),
    .reset_i(reset_i),
    .bus    (sram_bus)
  );

  tile_bootrom #(.DW(DW)) u_bootrom (
    .clk    (clk),
    .reset_i(reset_i),
    .bus    (boot_bus)
  );

endmodule

// ==== tests/tile_assertions.sv ====
/* Bus protocol assertions */

module tile_assertions import tile_pkg::*; (
  input logic               clk,
  input logic               reset_i,
  input logic [TILE_AW-1:0] m0_adr_i,
  input logic [TILE_DW-1:0] m0_dat_i,
  input logic [TILE_SW-1:0] m0_sel_i,
  input logic               m0_we_i,
  input logic               m0_stb_i,
  input logic               m0_ack_o,
  input logic               m0_err_o,
  input logic [TILE_AW-1:0] m1_adr_i,
  input logic [TILE_DW-1:0] m1_dat_i,
  input logic [TILE_SW-1:0] m1_sel_i,
  input logic               m1_we_i,
  input logic               m1_stb_i,
  input logic               m1_ack_o,
  input logic               m1_err_o
);

  // Response is ack or err, never both
  m0_excl: assert property (@(posedge clk) disable iff (reset_i) !(m0_ack_o && m0_err_o))
    else $error("Master 0 ack and err high together");
  m1_excl: assert property (@(posedge clk) disable iff (reset_i) !(m1_ack_o && m1_err_o))
    else $error("Master 1 ack and err high together");

  // Single-cycle response pulse
  m0_pulse: assert property (@(posedge clk) disable iff (reset_i)
    (m0_ack_o || m0_err_o) |=> !(m0_ack_o || m0_err_o))
    else $error("Master 0 response longer than one cycle");
  m1_pulse: assert property (@(posedge clk) disable iff (reset_i)
    (m1_ack_o || m1_err_o) |=> !(m1_ack_o || m1_err_o))
    else $error("Master 1 response longer than one cycle");

  // Request frozen until answered
  m0_hold: assert property (@(posedge clk) disable iff (reset_i)
    (m0_stb_i && !m0_ack_o && !m0_err_o) |=>
      m0_stb_i && $stable({m0_adr_i, m0_dat_i, m0_sel_i, m0_we_i}))
    else $error("Master 0 request changed before its response");
  m1_hold: assert property (@(posedge clk) disable iff (reset_i)
    (m1_stb_i && !m1_ack_o && !m1_err_o) |=>
      m1_stb_i && $stable({m1_adr_i, m1_dat_i, m1_sel_i, m1_we_i}))
    else $error("Master 1 request changed before its response");

endmodule

// ==== tests/tile_checker.sv ====
/* Bus response checker */

module tile_checker import tile_pkg::*; (
  input  logic               clk,
  input  logic               reset_i,
  input  logic [TILE_AW-1:0] adr_i [2],
  input  logic [TILE_DW-1:0] wdat_i [2],
  input  logic [TILE_SW-1:0] sel_i [2],
  input  logic               we_i [2],
  input  logic               stb_i [2],
  input  logic               exp_err_i [2],
  input  logic [TILE_DW-1:0] rdat_i [2],
  input  logic               ack_i [2],
  input  logic               err_i [2],
  output int                 tests_o,
  output int                 fails_o
);

  // Reference copy of the data memory
  logic [TILE_DW-1:0] shadow [SRAM_WORDS];

  always @(posedge clk) begin : compare
    logic [TILE_AW-1:0]            a;
    logic [$clog2(SRAM_WORDS)-1:0] widx;
    logic                          is_sram;
    logic                          map_err;
    logic [TILE_DW-1:0]            exp_dat;
    if (reset_i) begin
      tests_o = 0;
      fails_o = 0;
    end else begin
      for (int m = 0; m < 2; m++) begin
        a       = adr_i[m];
        widx    = a[$clog2(SRAM_WORDS)+1:2];
        is_sram = a < 4 * SRAM_WORDS;
        // Reads of the top 256 MB hit the ROM, anything else errors
        map_err = !is_sram && !(a[TILE_AW-1:TILE_AW-4] == BOOT_MATCH && !we_i[m]);
        if (is_sram) begin
          exp_dat = shadow[widx];
        end else if (int'(a[TILE_AW-5:2]) < BOOT_WORDS) begin
          exp_dat = BOOT_IMAGE[a[4:2]];
        end else begin
          exp_dat = '0;
        end
        if ((ack_i[m] || err_i[m]) && !stb_i[m]) begin
          $display("Master %0d got a response at %0t with no request", m, $time);
          fails_o++;
        end else if (ack_i[m] || err_i[m]) begin
          tests_o++;
          if (ack_i[m] == map_err || err_i[m] != map_err || exp_err_i[m] != map_err ||
              (!we_i[m] && !map_err && rdat_i[m] !== exp_dat)) begin
            $display("FAIL %0t: m%0d %s %h ack %b err %b data %h, expected err %b (file %b) data %h",
                     $time, m, we_i[m] ? "wr" : "rd", a, ack_i[m], err_i[m], rdat_i[m],
                     map_err, exp_err_i[m], exp_dat);
            fails_o++;
          end else begin
            $display("ok   %0t: m%0d %s %h", $time, m, we_i[m] ? "wr" : "rd", a);
          end
          // Only selected byte lanes change
          if (ack_i[m] && we_i[m] && is_sram) begin
            for (int b = 0; b < TILE_SW; b++) begin
              if (sel_i[m][b]) begin
                shadow[widx][b*8 +: 8] = wdat_i[m][b*8 +: 8];
              end
            end
          end
        end
      end
    end
  end

endmodule

// ==== tests/tile_tb.sv ====
/* Compute tile bus testbench */

module tile_tb import tile_pkg::*; ();

  localparam int FIELDS    = 7;
  localparam int MAX_WORDS = 64 * FIELDS;
  localparam int TIMEOUT   = 50;

  logic               clk;
  logic               reset_i;
  logic [TILE_AW-1:0] adr [2];
  logic [TILE_DW-1:0] wdat [2];
  logic [TILE_SW-1:0] sel [2];
  logic               we [2];
  logic               stb [2];
  logic               exp_err [2];
  logic [TILE_DW-1:0] rdat [2];
  logic               ack [2];
  logic               err [2];
  logic [31:0]        pat [MAX_WORDS];
  int                 tests;
  int                 fails;
  int                 issued;
  int                 timeouts;
  int                 idx;

  tile_top UUT (
    .clk     (clk),
    .reset_i (reset_i),
    .m0_adr_i(adr[0]),
    .m0_dat_i(wdat[0]),
    .m0_sel_i(sel[0]),
    .m0_we_i (we[0]),
    .m0_cyc_i(stb[0]),
    .m0_stb_i(stb[0]),
    .m0_dat_o(rdat[0]),
    .m0_ack_o(ack[0]),
    .m0_err_o(err[0]),
    .m1_adr_i(adr[1]),
    .m1_dat_i(wdat[1]),
    .m1_sel_i(sel[1]),
    .m1_we_i (we[1]),
    .m1_cyc_i(stb[1]),
    .m1_stb_i(stb[1]),
    .m1_dat_o(rdat[1]),
    .m1_ack_o(ack[1]),
    .m1_err_o(err[1])
  );

  tile_checker u_checker (
    .clk      (clk),
    .reset_i  (reset_i),
    .adr_i    (adr),
    .wdat_i   (wdat),
    .sel_i    (sel),
    .we_i     (we),
    .stb_i    (stb),
    .exp_err_i(exp_err),
    .rdat_i   (rdat),
    .ack_i    (ack),
    .err_i    (err),
    .tests_o  (tests),
    .fails_o  (fails)
  );

  bind tile_top tile_assertions u_assertions (.*);

  initial clk = 1'b0;
  always #5 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Master driver
  //////////////////////////////////////////////////////////////////////

  // Request held through the rising edge that carries ack or err
  task automatic run_access(input int m, input int base);
    int cycles;
    cycles     = 0;
    adr[m]     = pat[base+2];
    wdat[m]    = (pat[base+1] == 2) ? $urandom() : pat[base+3];
    sel[m]     = pat[base+4][TILE_SW-1:0];
    we[m]      = (pat[base+1] != 0);
    exp_err[m] = pat[base+5][0];
    stb[m]     = 1'b1;
    issued++;
    do begin
      @(negedge clk);
      cycles++;
    end while (!ack[m] && !err[m] && cycles < TIMEOUT);
    if (!ack[m] && !err[m]) begin
      $display("Timeout: master %0d got no response for address %h", m, adr[m]);
      timeouts++;
    end
    @(negedge clk);
    stb[m] = 1'b0;
    we[m]  = 1'b0;
  endtask

  initial begin
    void'($urandom(66028));
    issued   = 0;
    timeouts = 0;
    reset_i  = 1'b1;
    for (int m = 0; m < 2; m++) begin
      adr[m]     = '0;
      wdat[m]    = '0;
      sel[m]     = '0;
      we[m]      = 1'b0;
      stb[m]     = 1'b0;
      exp_err[m] = 1'b0;
    end
    $readmemh("tests/tile_patterns.txt", pat);
    repeat (2) @(negedge clk);
    reset_i = 1'b0;
    // Idle stretch, stray responses show up in the checker
    repeat (4) @(negedge clk);
    idx = 0;
    while (idx < MAX_WORDS && pat[idx] != 32'hff) begin
      if (pat[idx+6][0]) begin
        fork
          run_access(int'(pat[idx][0]), idx);
          run_access(int'(pat[idx+FIELDS][0]), idx + FIELDS);
        join
        idx += 2 * FIELDS;
      end else begin
        run_access(int'(pat[idx][0]), idx);
        idx += FIELDS;
      end
      @(negedge clk);
    end
    repeat (3) @(negedge clk);
    if (tests != issued) begin
      $display("Checker saw %0d responses for %0d issued accesses", tests, issued);
    end
    $display("Done: %0d tests, %0d failed, %0d timeouts", tests, fails, timeouts);
    if (fails == 0 && timeouts == 0 && tests == issued) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== tests/tile_patterns.txt ====
// master we address wdata sel err conc, all hex; we 2 writes random data
// conc 1 starts this line and the next one together; master ff ends the list
0 1 00000010 11223344 f 0 0
0 1 00000010 aabbccdd 5 0 0 // bytes 0 and 2 only
1 0 00000010 00000000 0 0 0
0 2 00000020 00000000 f 0 0
1 0 00000020 00000000 0 0 0
1 0 f0000008 00000000 0 0 0
0 0 f0000040 00000000 0 0 0 // past the image
0 0 00000400 00000000 0 1 0 // just above the data memory
1 1 80000000 12345678 f 1 0
0 1 f0000004 deadbeef f 1 0 // ROM is read-only
1 0 f0000004 00000000 0 0 0
0 1 00000100 0a0b0c0d f 0 1
1 1 00000104 50607080 f 0 0
0 0 00000104 00000000 0 0 1
1 0 00000100 00000000 0 0 0
0 0 f0000000 00000000 0 0 1
1 2 000003fc 00000000 f 0 0
0 0 000003fc 00000000 0 0 0
ff 0 0 0 0 0 0

// ==== compile.f ====
rtl/tile_pkg.sv
rtl/wb_if.sv
rtl/tile_bus_arbiter.sv
rtl/tile_addr_decoder.sv
rtl/tile_sram.sv
rtl/tile_bootrom.sv
rtl/tile_top.sv
tests/tile_assertions.sv
tests/tile_checker.sv
tests/tile_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tile_tb -f compile.f -o tile_sim
./obj_dir/tile_sim > sim.log 2>&1 || true
cat sim.log
grep -q "^Regression passed$" sim.log
